// ==== Bender.yml ====
package:
  name: axis_width_converter

dependencies: {}

sources:
  # packages first, the stages and top level depend on them
  - axis_cfg_pkg.sv
  - conv_state_pkg.sv
  - axis_upsizer.sv
  - axis_downsizer.sv
  - axis_width_converter.sv
  - target: test
    files:
      - tb_axis_width_converter.sv

// ==== axis_cfg_pkg.sv ====
// ****************************************
// stream configuration
// word widths and packing ratios for the
// 24 to 32 bit stream converter
// ****************************************
package axis_cfg_pkg;

  // width of the narrow words arriving from the source
  localparam int in_width = 24;

  // width of the wide words leaving toward the sink
  localparam int out_width = 32;

  // input words packed into one intermediate word
  localparam int up_ratio = 4;

  // output words split out of one intermediate word
  localparam int down_ratio = 3;

  // intermediate word between the two stages
  // in_width * up_ratio and out_width * down_ratio both give 96,
  // so the packed word divides evenly on the output side
  localparam int mid_width = in_width * up_ratio;

endpackage

// ==== axis_downsizer.sv ====
// ****************************************
// axis downsizer
// splits one wide stream word into narrow
// words, least significant first
// ****************************************
`timescale 1ns/1ps
module axis_downsizer #(
  parameter int dwidth = axis_cfg_pkg::mid_width,
  parameter int down = axis_cfg_pkg::down_ratio
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [dwidth-1:0]        in_data,
  input  logic                     in_valid,
  input  logic                     in_last,
  output logic                     in_ready,
  output logic [dwidth/down-1:0]   out_data,
  output logic                     out_valid,
  output logic                     out_last,
  input  logic                     out_ready
);

  import conv_state_pkg::*;

  localparam int sub_width = dwidth / down;
  localparam int idx_width = (down > 1) ? $clog2(down) : 1;

  split_state_e state;
  logic [idx_width-1:0] sub_idx;

  // held wide word, slice 0 goes out first
  logic [down-1:0][sub_width-1:0] word_q;
  logic last_q;

  logic load;
  logic out_fire;
  logic final_slice;

  assign out_valid = (state == split_drain);
  assign out_fire = out_valid & out_ready;
  assign final_slice = (sub_idx == idx_width'(down - 1));

  // reload right behind the final slice so the output keeps going
  assign in_ready = (state == split_empty) | (out_fire & final_slice);
  assign load = in_valid & in_ready;

  assign out_data = word_q[sub_idx];
  // only the closing slice of a packet carries last
  assign out_last = last_q & final_slice;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= split_empty;
      sub_idx <= '0;
    end else begin
      if (load) begin
        state <= split_drain;
        sub_idx <= '0;
      end else if (out_fire) begin
        if (final_slice) begin
          state <= split_empty;
          sub_idx <= '0;
        end else begin
          sub_idx <= sub_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      word_q <= in_data;
      last_q <= in_last;
    end
  end

endmodule

// ==== axis_upsizer.sv ====
// ****************************************
// axis upsizer
// packs narrow stream words into one wide
// word, zero filling a short last group
// ****************************************
`timescale 1ns/1ps
module axis_upsizer #(
  parameter int dwidth = axis_cfg_pkg::in_width,
  parameter int up = axis_cfg_pkg::up_ratio
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [dwidth-1:0]     in_data,
  input  logic                  in_valid,
  input  logic                  in_last,
  output logic                  in_ready,
  output logic [dwidth*up-1:0]  out_data,
  output logic                  out_valid,
  output logic                  out_last,
  input  logic                  out_ready
);

  import conv_state_pkg::*;

  // index needs at least one bit, even for a ratio of 1
  localparam int idx_width = (up > 1) ? $clog2(up) : 1;

  pack_state_e state;
  logic [idx_width-1:0] fill_idx;

  // subword slots, slot 0 holds the earliest word
  logic [up-1:0][dwidth-1:0] slots;
  logic last_q;

  logic accept;
  logic out_fire;
  logic group_done;

  assign out_valid = (state == pack_hold);
  assign out_fire = out_valid & out_ready;

  // a new group may start in the same cycle the packed word leaves
  assign in_ready = (state != pack_hold) | out_ready;
  assign accept = in_valid & in_ready;

  // this word closes the group, either full or cut short by last
  assign group_done = in_last | (fill_idx == idx_width'(up - 1));

  assign out_data = slots;
  assign out_last = last_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= pack_collect;
      fill_idx <= '0;
    end else begin
      if (accept) begin
        if (group_done) begin
          state <= pack_hold;
          fill_idx <= '0;
        end else begin
          state <= pack_collect;
          fill_idx <= fill_idx + 1'b1;
        end
      end else if (out_fire) begin
        state <= pack_collect;
      end
    end
  end

  // slot writes, with the tail cleared when a packet ends early
  always_ff @(posedge clk) begin
    if (accept) begin
      for (int i = 0; i < up; i++) begin
        if (i == int'(fill_idx)) begin
          slots[i] <= in_data;
        end else if (in_last && (i > int'(fill_idx))) begin
          slots[i] <= '0;
        end
      end
      if (group_done) begin
        last_q <= in_last;
      end
    end
  end

endmodule

// ==== axis_width_converter.sv ====
// ****************************************
// axis width converter
// 24 bit to 32 bit stream, packs 4 words
// then splits the result into 3
// ****************************************
`timescale 1ns/1ps
module axis_width_converter (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [axis_cfg_pkg::in_width-1:0]  in_data,
  input  logic                            in_valid,
  input  logic                            in_last,
  output logic                            in_ready,
  output logic [axis_cfg_pkg::out_width-1:0] out_data,
  output logic                            out_valid,
  output logic                            out_last,
  input  logic                            out_ready
);

  import axis_cfg_pkg::*;

  // intermediate stream between the two stages
  logic [mid_width-1:0] mid_data;
  logic mid_valid;
  logic mid_last;
  logic mid_ready;

  axis_upsizer #(
    .dwidth(in_width),
    .up(up_ratio)
  ) upsizer_i (
    .clk,
    .reset,
    .in_data,
    .in_valid,
    .in_last,
    .in_ready,
    .out_data(mid_data),
    .out_valid(mid_valid),
    .out_last(mid_last),
    .out_ready(mid_ready)
  );

  axis_downsizer #(
    .dwidth(mid_width),
    .down(down_ratio)
  ) downsizer_i (
    .clk,
    .reset,
    .in_data(mid_data),
    .in_valid(mid_valid),
    .in_last(mid_last),
    .in_ready(mid_ready),
    .out_data,
    .out_valid,
    .out_last,
    .out_ready
  );

endmodule

// ==== compile.f ====
axis_cfg_pkg.sv
conv_state_pkg.sv
axis_upsizer.sv
axis_downsizer.sv
axis_width_converter.sv
tb_axis_width_converter.sv

// ==== conv_state_pkg.sv ====
// ****************************************
// converter state types
// FSM states of the packing and splitting
// stages
// ****************************************
package conv_state_pkg;

  // upsizer: gathering subwords, or holding a packed word
  typedef enum logic {
    pack_collect = 1'b0,
    pack_hold    = 1'b1
  } pack_state_e;

  // downsizer: nothing held, or handing out slices
  typedef enum logic {
    split_empty = 1'b0,
    split_drain = 1'b1
  } split_state_e;

endpackage

// ==== tb_axis_width_converter.sv ====
// ****************************************
// testbench for the axis width converter
// random packets in, scoreboard and
// concurrent assertions on the output
// ****************************************
`timescale 1ns/1ps
module tb_axis_width_converter;

  import axis_cfg_pkg::*;

  logic clk;
  logic reset;
  logic [in_width-1:0] in_data;
  logic in_valid;
  logic in_last;
  logic in_ready;
  logic [out_width-1:0] out_data;
  logic out_valid;
  logic out_last;
  logic out_ready;

  int seed = 85;
  int short_lens[9] = '{1, 2, 3, 5, 6, 7, 9, 10, 11};

  // scoreboard state updated once per rising edge
  logic [out_width-1:0] exp_data_q[$];
  bit exp_last_q[$];
  logic [out_width-1:0] exp_data;
  bit exp_last;
  int pending;
  int grp_cnt;
  logic [mid_width-1:0] acc;
  logic [out_width-1:0] hold_data;
  logic hold_last;

  bit ready_random;
  bit lat_check;
  int error_count;
  int words_out;
  int planned_words;
  int cycle_count;
  int tests_run;
  int tests_failed;

  axis_width_converter axis_width_converter_i (
    .clk,
    .reset,
    .in_data,
    .in_valid,
    .in_last,
    .in_ready,
    .out_data,
    .out_valid,
    .out_last,
    .out_ready
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // sink ready is random while ready_random is set and high otherwise
  initial begin : ready_driver
    forever begin
      @(negedge clk);
      if (ready_random) begin
        out_ready = $random(seed) & 1;
      end else begin
        out_ready = 1'b1;
      end
    end
  end

  // expected words are the packet words packed lsb first with the short
  // group zero padded, then cut into output slices
  always @(posedge clk) begin
    if (reset) begin
      exp_data_q.delete();
      exp_last_q.delete();
      grp_cnt = 0;
      acc = '0;
    end else begin
      if (out_valid && out_ready) begin
        words_out++;
        if (exp_data_q.size() > 0) begin
          void'(exp_data_q.pop_front());
          void'(exp_last_q.pop_front());
        end
      end
      if (in_valid && in_ready) begin
        acc[grp_cnt*in_width +: in_width] = in_data;
        if (in_last || grp_cnt == up_ratio - 1) begin
          for (int k = 0; k < down_ratio; k++) begin
            exp_data_q.push_back(acc[k*out_width +: out_width]);
            exp_last_q.push_back(in_last && (k == down_ratio - 1));
          end
          acc = '0;
          grp_cnt = 0;
        end else begin
          grp_cnt++;
        end
      end
    end
    pending = exp_data_q.size();
    exp_data = (pending > 0) ? exp_data_q[0] : '0;
    exp_last = (pending > 0) ? exp_last_q[0] : 1'b0;
    hold_data <= out_data;
    hold_last <= out_last;
  end

  reset_check: assert property (@(posedge clk) $fell(reset) |-> (!out_valid && in_ready))
    else begin
      $display("[FAIL] %0t out_valid/in_ready after reset expected 0/1 got %b/%b",
               $time, $sampled(out_valid), $sampled(in_ready));
      error_count++;
    end

  extra_check: assert property (@(posedge clk) disable iff (reset)
    (out_valid && out_ready) |-> pending > 0)
    else begin
      $display("output word %h at %0t arrived with no word expected",
               $sampled(out_data), $time);
      error_count++;
    end

  data_check: assert property (@(posedge clk) disable iff (reset)
    (out_valid && out_ready && pending > 0) |-> out_data == exp_data)
    else begin
      $display("[FAIL] %0t out_data expected %h got %h",
               $time, $sampled(exp_data), $sampled(out_data));
      error_count++;
    end

  last_check: assert property (@(posedge clk) disable iff (reset)
    (out_valid && out_ready && pending > 0) |-> out_last == exp_last)
    else begin
      $display("[FAIL] %0t out_last expected %b got %b",
               $time, $sampled(exp_last), $sampled(out_last));
      error_count++;
    end

  // a stalled word must not move or vanish
  hold_check: assert property (@(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && out_data == hold_data && out_last == hold_last))
    else begin
      $display("[FAIL] %0t out_data expected %h got %h (out_last %b/%b, out_valid %b)",
               $time, $sampled(hold_data), $sampled(out_data),
               $sampled(hold_last), $sampled(out_last), $sampled(out_valid));
      error_count++;
    end

  // group closing into an idle pipe shows up two edges later
  latency_check: assert property (@(posedge clk) disable iff (reset)
    (lat_check && in_valid && in_ready && pending == 0 &&
     (in_last || grp_cnt == up_ratio - 1)) |-> ##2 out_valid)
    else begin
      $display("[FAIL] %0t out_valid expected 1 got %b", $time, $sampled(out_valid));
      error_count++;
    end

  ready_check: assert property (@(posedge clk) disable iff (reset) !in_ready |-> out_valid)
    else begin
      $display("in_ready dropped at %0t while no output word was waiting", $time);
      error_count++;
    end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count <= 40 * planned_words + 200) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("watchdog: the run stalled after %0d cycles with %0d words still expected",
             cycle_count, pending);
    $display("=== FAIL ===");
    $finish;
  end

  task automatic send_packet(input int len, input bit gaps);
    int i;
    planned_words += len;
    for (i = 0; i < len; i++) begin
      if (gaps) begin
        while (($random(seed) & 3) == 0) begin
          in_valid = 1'b0;
          @(negedge clk);
        end
      end
      in_data = $random(seed);
      in_valid = 1'b1;
      in_last = (i == len - 1);
      @(posedge clk);
      while (!in_ready) @(posedge clk);
      @(negedge clk);
    end
    in_valid = 1'b0;
    in_last = 1'b0;
  endtask

  task automatic wait_drain();
    while (pending != 0) @(negedge clk);
    repeat (4) @(negedge clk);
  endtask

  // mode flags change on the rising edge away from the falling edge drivers
  task automatic select_mode(input bit rand_ready, input bit latency);
    @(posedge clk);
    ready_random = rand_ready;
    lat_check = latency;
    @(negedge clk);
  endtask

  task automatic report_test(input string name, input int err_start, input int out_start);
    int errs;
    errs = error_count - err_start;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("test %-12s %s, %0d output words, %0d errors", name,
             (errs == 0) ? "ok" : "errors found", words_out - out_start, errs);
  endtask

  initial begin : main_flow
    int err_start;
    int out_start;
    int len;
    reset = 1'b1;
    in_data = '0;
    in_valid = 1'b0;
    in_last = 1'b0;
    out_ready = 1'b1;
    ready_random = 1'b0;
    lat_check = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    err_start = error_count;
    out_start = words_out;
    repeat (2) @(negedge clk);
    report_test("reset_state", err_start, out_start);

    err_start = error_count;
    out_start = words_out;
    select_mode(1'b0, 1'b1);
    send_packet(4, 1'b0);
    send_packet(8, 1'b0);
    send_packet(12, 1'b0);
    wait_drain();
    report_test("full_groups", err_start, out_start);

    err_start = error_count;
    out_start = words_out;
    foreach (short_lens[j]) begin
      send_packet(short_lens[j], 1'b0);
      wait_drain();
    end
    report_test("short_groups", err_start, out_start);

    err_start = error_count;
    out_start = words_out;
    select_mode(1'b1, 1'b0);
    repeat (12) begin
      len = 1 + (($random(seed) & 32'h7fff_ffff) % 20);
      send_packet(len, 1'b0);
    end
    wait_drain();
    report_test("backpressure", err_start, out_start);

    err_start = error_count;
    out_start = words_out;
    repeat (20) begin
      len = 1 + (($random(seed) & 32'h7fff_ffff) % 20);
      send_packet(len, 1'b1);
    end
    wait_drain();
    report_test("random_mix", err_start, out_start);

    $display("tests run %0d, tests failed %0d, output words %0d, errors %0d",
             tests_run, tests_failed, words_out, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
